// File: Bender.yml
package:
  name: rv_pipe

sources:
  - design/rv_core_pkg.sv
  - design/rv_regfile.sv
  - design/rv_decode.sv
  - design/rv_forward.sv
  - design/rv_alu.sv
  - design/rv_execute.sv
  - design/rv_writeback.sv
  - design/rv_pipe_top.sv
  - target: test
    files:
      - test/rv_pipe_tb.sv

// File: design/rv_alu.sv
`timescale 1ns/10ps

module rv_alu import rv_core_pkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  alu_op_e         op,
  output logic [XLEN-1:0] res
);

  logic [4:0] shamt;

  // Only the low five bits shift in RV32I
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD: begin
        res = a + b;
      end
      ALU_SUB: begin
        res = a - b;
      end
      ALU_SLL: begin
        res = a << shamt;
      end
      // Compares give 0 or 1
      ALU_SLT: begin
        res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      end
      ALU_SLTU: begin
        res = {{(XLEN-1){1'b0}}, a < b};
      end
      ALU_XOR: begin
        res = a ^ b;
      end
      ALU_SRL: begin
        res = a >> shamt;
      end
      ALU_SRA: begin
        res = $unsigned($signed(a) >>> shamt);
      end
      ALU_OR: begin
        res = a | b;
      end
      ALU_AND: begin
        res = a & b;
      end
      // lui
      default: res = b;
    endcase
  end

endmodule

// File: design/rv_core_pkg.sv
package rv_core_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data path width
  localparam int XLEN   = 32;
  // Register address width, 32 architectural registers
  localparam int REG_AW = 5;

  //////////////////////////////////////////////////
  // Major opcodes kept in this core
  //////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // Operand B straight through, for lui
    ALU_PASS_B
  } alu_op_e;

  // funct3 codes, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 selecting sub and sra
  localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

// File: design/rv_decode.sv
`timescale 1ns/10ps

module rv_decode import rv_core_pkg::*; (
  input  logic              bus,
  input  logic              rst_n,
  input  logic              hold,
  input  logic              instr_valid,
  input  logic [31:0]       instr,
  input  logic [XLEN-1:0]   pc,
  input  logic [XLEN-1:0]   rs1_data,
  input  logic [XLEN-1:0]   rs2_data,
  output logic [REG_AW-1:0] rs1_addr,
  output logic [REG_AW-1:0] rs2_addr,
  output logic              illegal,
  output logic              ex_valid,
  output alu_op_e           ex_alu_op,
  output logic [REG_AW-1:0] ex_rs1,
  output logic [REG_AW-1:0] ex_rs2,
  output logic [XLEN-1:0]   ex_rs1_val,
  output logic [XLEN-1:0]   ex_rs2_val,
  output logic [XLEN-1:0]   ex_imm,
  output logic [XLEN-1:0]   ex_pc,
  output logic              ex_use_imm,
  output logic              ex_use_pc,
  output logic              ex_regwrite,
  output logic [REG_AW-1:0] ex_rd
);

  opcode_e           opcode;
  logic [2:0]        funct3;
  logic              alt;
  logic [REG_AW-1:0] rd;
  logic              legal;
  alu_op_e           alu_op;
  logic [XLEN-1:0]   imm;
  logic              use_imm;
  logic              use_pc;

  // Field extraction
  assign opcode   = opcode_e'(instr[6:0]);
  assign rd       = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign alt      = (instr[31:25] == F7_ALT);

  // Control word
  always_comb begin
    legal   = 1'b1;
    alu_op  = ALU_ADD;
    imm     = '0;
    use_imm = 1'b0;
    use_pc  = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        use_imm = (opcode == OPC_OP_IMM);
        // I-immediate, sign extended
        imm     = {{(XLEN-12){instr[31]}}, instr[31:20]};
        case (funct3)
          // sub only exists in the register form
          F3_ADD_SUB: alu_op = (alt && !use_imm) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SR:      alu_op = alt ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op = ALU_OR;
          default:    alu_op = ALU_AND;
        endcase
        // Immediate shifts take shamt only
        if (use_imm && (funct3 == F3_SLL || funct3 == F3_SR)) begin
          imm = {{(XLEN-5){1'b0}}, instr[24:20]};
        end
      end
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        imm     = {instr[31:12], 12'b0};
        use_imm = 1'b1;
      end
      OPC_AUIPC: begin
        imm     = {instr[31:12], 12'b0};
        use_imm = 1'b1;
        use_pc  = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      illegal     <= 1'b0;
      ex_valid    <= 1'b0;
      ex_regwrite <= 1'b0;
      ex_alu_op   <= ALU_ADD;
      ex_rd       <= '0;
    end else if (!hold) begin
      illegal     <= instr_valid && !legal;
      ex_valid    <= instr_valid && legal;
      // x0 destination never writes
      ex_regwrite <= instr_valid && legal && (rd != '0);
      ex_alu_op   <= alu_op;
      ex_rd       <= rd;
    end
  end

  // Payload
  always_ff @(posedge bus) begin
    if (!hold) begin
      ex_rs1     <= rs1_addr;
      ex_rs2     <= rs2_addr;
      ex_rs1_val <= rs1_data;
      ex_rs2_val <= rs2_data;
      ex_imm     <= imm;
      ex_pc      <= pc;
      ex_use_imm <= use_imm;
      ex_use_pc  <= use_pc;
    end
  end

  // Producer must stall while the pipe is frozen
  a_no_issue_in_hold: assert property (@(posedge bus) disable iff (!rst_n)
    hold |-> !instr_valid);

endmodule

// File: design/rv_execute.sv
`timescale 1ns/10ps

module rv_execute import rv_core_pkg::*; (
  input  logic              bus,
  input  logic              rst_n,
  input  logic              hold,
  input  logic              ex_valid,
  input  alu_op_e           ex_alu_op,
  input  logic [REG_AW-1:0] ex_rs1,
  input  logic [REG_AW-1:0] ex_rs2,
  input  logic [XLEN-1:0]   ex_rs1_val,
  input  logic [XLEN-1:0]   ex_rs2_val,
  input  logic [XLEN-1:0]   ex_imm,
  input  logic [XLEN-1:0]   ex_pc,
  input  logic              ex_use_imm,
  input  logic              ex_use_pc,
  input  logic              ex_regwrite,
  input  logic [REG_AW-1:0] ex_rd,
  input  logic              wb_valid,
  input  logic [REG_AW-1:0] wb_rd,
  input  logic [XLEN-1:0]   wb_data,
  output logic              exwb_valid,
  output logic              exwb_regwrite,
  output logic [REG_AW-1:0] exwb_rd,
  output logic [XLEN-1:0]   exwb_res
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;

  rv_forward fwd_i (
    .rs1(ex_rs1), .rs2(ex_rs2), .rs1_val(ex_rs1_val), .rs2_val(ex_rs2_val),
    .imm(ex_imm), .pc(ex_pc), .use_imm(ex_use_imm), .use_pc(ex_use_pc),
    .exwb_regwrite(exwb_regwrite), .exwb_rd(exwb_rd), .exwb_res(exwb_res),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
    .op_a(op_a), .op_b(op_b)
  );

  rv_alu alu_i (.a(op_a), .b(op_b), .op(ex_alu_op), .res(alu_res));

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      exwb_valid    <= 1'b0;
      exwb_regwrite <= 1'b0;
      exwb_rd       <= '0;
    end else if (!hold) begin
      exwb_valid    <= ex_valid;
      exwb_regwrite <= ex_regwrite;
      exwb_rd       <= ex_rd;
    end
  end

  // Result payload
  always_ff @(posedge bus) begin
    if (!hold) exwb_res <= alu_res;
  end

  // Decode only sets regwrite on valid instructions
  a_regwrite_valid: assert property (@(posedge bus) disable iff (!rst_n)
    exwb_regwrite |-> exwb_valid);

endmodule

// File: design/rv_forward.sv
`timescale 1ns/10ps

module rv_forward import rv_core_pkg::*; (
  input  logic [REG_AW-1:0] rs1,
  input  logic [REG_AW-1:0] rs2,
  input  logic [XLEN-1:0]   rs1_val,
  input  logic [XLEN-1:0]   rs2_val,
  input  logic [XLEN-1:0]   imm,
  input  logic [XLEN-1:0]   pc,
  input  logic              use_imm,
  input  logic              use_pc,
  input  logic              exwb_regwrite,
  input  logic [REG_AW-1:0] exwb_rd,
  input  logic [XLEN-1:0]   exwb_res,
  input  logic              wb_valid,
  input  logic [REG_AW-1:0] wb_rd,
  input  logic [XLEN-1:0]   wb_data,
  output logic [XLEN-1:0]   op_a,
  output logic [XLEN-1:0]   op_b
);

  logic [XLEN-1:0] rs1_fwd;
  logic [XLEN-1:0] rs2_fwd;

  // Nearest producer first, then writeback, then the register file copy
  assign rs1_fwd = (exwb_regwrite && exwb_rd == rs1) ? exwb_res :
                   (wb_valid && wb_rd == rs1)        ? wb_data  : rs1_val;
  assign rs2_fwd = (exwb_regwrite && exwb_rd == rs2) ? exwb_res :
                   (wb_valid && wb_rd == rs2)        ? wb_data  : rs2_val;

  // Operand A takes the pc for auipc
  assign op_a = use_pc  ? pc  : rs1_fwd;
  // Operand B takes the immediate for I and U forms
  assign op_b = use_imm ? imm : rs2_fwd;

endmodule

// File: design/rv_pipe_top.sv
`timescale 1ns/10ps

module rv_pipe_top import rv_core_pkg::*; (
  input  logic              bus,
  input  logic              rst_n,
  input  logic              hold,
  input  logic              instr_valid,
  input  logic [31:0]       instr,
  input  logic [XLEN-1:0]   pc,
  output logic              illegal,
  output logic              wb_valid,
  output logic [REG_AW-1:0] wb_rd,
  output logic [XLEN-1:0]   wb_data
);

  // Register file ports
  logic [REG_AW-1:0] rs1_addr, rs2_addr, rf_addr;
  logic [XLEN-1:0]   rs1_data, rs2_data, rf_data;
  logic              rf_we;

  // ID/EX
  logic              ex_valid, ex_use_imm, ex_use_pc, ex_regwrite;
  alu_op_e           ex_alu_op;
  logic [REG_AW-1:0] ex_rs1, ex_rs2, ex_rd;
  logic [XLEN-1:0]   ex_rs1_val, ex_rs2_val, ex_imm, ex_pc;

  // EX/WB
  logic              exwb_valid, exwb_regwrite;
  logic [REG_AW-1:0] exwb_rd;
  logic [XLEN-1:0]   exwb_res;

  rv_regfile rf_i (
    .bus(bus), .rst_n(rst_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .we(rf_we), .wr_addr(rf_addr), .wr_data(rf_data),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_decode dec_i (
    .bus(bus), .rst_n(rst_n), .hold(hold), .instr_valid(instr_valid),
    .instr(instr), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .illegal(illegal),
    .ex_valid(ex_valid), .ex_alu_op(ex_alu_op), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
    .ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val), .ex_imm(ex_imm),
    .ex_pc(ex_pc), .ex_use_imm(ex_use_imm), .ex_use_pc(ex_use_pc),
    .ex_regwrite(ex_regwrite), .ex_rd(ex_rd)
  );

  rv_execute exe_i (
    .bus(bus), .rst_n(rst_n), .hold(hold), .ex_valid(ex_valid),
    .ex_alu_op(ex_alu_op), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
    .ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val), .ex_imm(ex_imm),
    .ex_pc(ex_pc), .ex_use_imm(ex_use_imm), .ex_use_pc(ex_use_pc),
    .ex_regwrite(ex_regwrite), .ex_rd(ex_rd),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
    .exwb_valid(exwb_valid), .exwb_regwrite(exwb_regwrite),
    .exwb_rd(exwb_rd), .exwb_res(exwb_res)
  );

  rv_writeback wb_i (
    .bus(bus), .rst_n(rst_n), .hold(hold), .exwb_regwrite(exwb_regwrite),
    .exwb_rd(exwb_rd), .exwb_res(exwb_res),
    .rf_we(rf_we), .rf_addr(rf_addr), .rf_data(rf_data),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_core_pkg::*; (
  input  logic              bus,
  input  logic              rst_n,
  input  logic [REG_AW-1:0] rs1_addr,
  input  logic [REG_AW-1:0] rs2_addr,
  input  logic              we,
  input  logic [REG_AW-1:0] wr_addr,
  input  logic [XLEN-1:0]   wr_data,
  output logic [XLEN-1:0]   rs1_data,
  output logic [XLEN-1:0]   rs2_data
);

  // x1 to x31, x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  // Asynchronous reads, x0 hardwired to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Decode drops regwrite for rd zero, so no write should reach x0
  a_no_x0_write: assert property (@(posedge bus) disable iff (!rst_n)
    we |-> wr_addr != '0);

endmodule

// File: design/rv_writeback.sv
`timescale 1ns/10ps

module rv_writeback import rv_core_pkg::*; (
  input  logic              bus,
  input  logic              rst_n,
  input  logic              hold,
  input  logic              exwb_regwrite,
  input  logic [REG_AW-1:0] exwb_rd,
  input  logic [XLEN-1:0]   exwb_res,
  output logic              rf_we,
  output logic [REG_AW-1:0] rf_addr,
  output logic [XLEN-1:0]   rf_data,
  output logic              wb_valid,
  output logic [REG_AW-1:0] wb_rd,
  output logic [XLEN-1:0]   wb_data
);

  // Register file write, frozen with the rest of the pipe
  assign rf_we   = exwb_regwrite && !hold;
  assign rf_addr = exwb_rd;
  assign rf_data = exwb_res;

  // Retirement report, also the older forwarding source
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      wb_rd    <= '0;
      wb_data  <= '0;
    end else if (!hold) begin
      wb_valid <= exwb_regwrite;
      // Keep last retired value between retirements
      if (exwb_regwrite) begin
        wb_rd   <= exwb_rd;
        wb_data <= exwb_res;
      end
    end
  end

endmodule

// File: tb.f
design/rv_core_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_forward.sv
design/rv_alu.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_pipe_top.sv
test/rv_pipe_tb.sv

// File: test/rv_pipe_tb.sv
`timescale 1ns/10ps

module rv_pipe_tb import rv_core_pkg::*; ();

  logic              bus;
  logic              rst_n;
  logic              hold;
  logic              instr_valid;
  logic [31:0]       instr;
  logic [XLEN-1:0]   pc;
  logic              illegal;
  logic              wb_valid;
  logic [REG_AW-1:0] wb_rd;
  logic [XLEN-1:0]   wb_data;

  // Reference register file and expected retirements, {rd, value}
  logic [XLEN-1:0]        model [0:31];
  logic [REG_AW+XLEN-1:0] exp_q [$];
  logic                   head_valid = 1'b0;
  logic [REG_AW-1:0]      head_rd    = '0;
  logic [XLEN-1:0]        head_data  = '0;

  // Issue markers, driven together with instr_valid
  logic issue_wr  = 1'b0;
  logic issue_bad = 1'b0;

  // Previous-edge copies for the checks
  logic              in_reset_q = 1'b0;
  logic              hold_q     = 1'b0;
  logic              bad_q      = 1'b0;
  logic              wb_valid_q = 1'b0;
  logic [REG_AW-1:0] wb_rd_q    = '0;
  logic [XLEN-1:0]   wb_data_q  = '0;

  integer          seed;
  int              error_count = 0;
  int              test_count  = 0;
  int              issued      = 0;
  int              retired     = 0;
  logic [XLEN-1:0] pc_cur;
  logic [4:0]      hist [0:2];

  rv_pipe_top dut_i (
    .bus(bus), .rst_n(rst_n), .hold(hold), .instr_valid(instr_valid),
    .instr(instr), .pc(pc), .illegal(illegal),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;
  end

  //////////////////////////////////////////////////
  // Reference model and encoders
  //////////////////////////////////////////////////

  function automatic logic legal_opcode(input logic [6:0] opc);
    return opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC};
  endfunction

  // Result per the RV32I rules, operands from the model
  function automatic logic [XLEN-1:0] model_result(input logic [31:0] ins,
                                                   input logic [XLEN-1:0] pc_v);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic            alt;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    opc = ins[6:0];
    f3  = ins[14:12];
    alt = (ins[31:25] == F7_ALT);
    a   = model[ins[19:15]];
    // I-immediate sign extended, shamt sits in its low bits
    b   = (opc == OPC_OP) ? model[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    if (opc == OPC_LUI) return {ins[31:12], 12'b0};
    if (opc == OPC_AUIPC) return pc_v + {ins[31:12], 12'b0};
    case (f3)
      F3_ADD_SUB: r = (opc == OPC_OP && alt) ? a - b : a + b;
      F3_SLL:     r = a << b[4:0];
      F3_SLT:     r = {31'b0, $signed(a) < $signed(b)};
      F3_SLTU:    r = {31'b0, a < b};
      F3_XOR:     r = a ^ b;
      F3_SR: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else     r = a >> b[4:0];
      end
      F3_OR:      r = a | b;
      default:    r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(1 + ($unsigned($random(seed)) % 31));
  endfunction

  // Random R or I form ALU instruction
  function automatic logic [31:0] random_alu(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [4:0] rd);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r  = $random(seed);
    f3 = r[2:0];
    f7 = (r[3] && (f3 == F3_ADD_SUB || f3 == F3_SR)) ? F7_ALT : 7'd0;
    if (r[4]) return enc_r(f7, rs2, rs1, f3, rd);
    if (f3 == F3_SLL || f3 == F3_SR) return enc_i({f7, r[9:5]}, rs1, f3, rd);
    return enc_i(r[31:20], rs1, f3, rd);
  endfunction

  function automatic void refresh_head();
    head_valid = (exp_q.size() != 0);
    if (head_valid) begin
      head_rd   = exp_q[0][REG_AW+XLEN-1:XLEN];
      head_data = exp_q[0][XLEN-1:0];
    end
  endfunction

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // Drive one instruction for one cycle, model updated at issue
  task automatic issue(input logic [31:0] ins);
    logic            ok;
    logic [4:0]      rd;
    logic [XLEN-1:0] val;
    rd = ins[11:7];
    ok = legal_opcode(ins[6:0]);
    if (ok && rd != 0) begin
      val = model_result(ins, pc_cur);
      model[rd] = val;
      exp_q.push_back({rd, val});
      refresh_head();
    end
    instr       = ins;
    pc          = pc_cur;
    instr_valid = 1'b1;
    issue_wr    = ok && rd != 0;
    issue_bad   = !ok;
    issued++;
    pc_cur = pc_cur + 4;
    @(negedge bus);
    instr_valid = 1'b0;
    issue_wr    = 1'b0;
    issue_bad   = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge bus);
  endtask

  // Wait for outstanding retirements, bounded
  task automatic finish_test(input string name);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 40) begin
      @(negedge bus);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout in test %s: %0d retirements never arrived", name, exp_q.size());
      error_count++;
    end
    idle(2);
    test_count++;
    $display("Test %-10s done, errors so far %0d", name, error_count);
  endtask

  //////////////////////////////////////////////////
  // Scoreboard bookkeeping
  //////////////////////////////////////////////////

  always @(posedge bus) begin
    // New retirement only if the writeback register was loaded last edge
    if (rst_n && wb_valid && !hold_q && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      retired++;
      refresh_head();
    end
    in_reset_q <= !rst_n;
    hold_q     <= hold;
    wb_valid_q <= wb_valid;
    wb_rd_q    <= wb_rd;
    wb_data_q  <= wb_data;
    if (!rst_n) bad_q <= 1'b0;
    else if (!hold) bad_q <= issue_bad;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge bus) in_reset_q |-> !wb_valid && !illegal)
    else begin
      $display("** Error: wb_valid = %h illegal = %h after reset, expected 0",
               $sampled(wb_valid), $sampled(illegal));
      error_count++;
    end

  a_retire_expected: assert property (@(posedge bus) disable iff (!rst_n)
    wb_valid && !hold_q |-> head_valid)
    else begin
      $display("Retirement of x%0d with no instruction outstanding", $sampled(wb_rd));
      error_count++;
    end

  a_retire_rd: assert property (@(posedge bus) disable iff (!rst_n)
    wb_valid && !hold_q && head_valid |-> wb_rd == head_rd)
    else begin
      $display("** Error: wb_rd = %h, expected %h", $sampled(wb_rd), $sampled(head_rd));
      error_count++;
    end

  a_retire_data: assert property (@(posedge bus) disable iff (!rst_n)
    wb_valid && !hold_q && head_valid |-> wb_data == head_data)
    else begin
      $display("** Error: wb_data = %h, expected %h", $sampled(wb_data),
               $sampled(head_data));
      error_count++;
    end

  // Three cycles from issue to retirement with hold low
  a_latency: assert property (@(posedge bus) disable iff (!rst_n)
    issue_wr ##1 !hold [*2] |=> wb_valid)
    else begin
      $display("Retirement missing three cycles after issue");
      error_count++;
    end

  a_hold_stable: assert property (@(posedge bus) disable iff (!rst_n)
    hold_q |-> wb_valid == wb_valid_q && wb_rd == wb_rd_q && wb_data == wb_data_q)
    else begin
      $display("** Error: under hold wb_valid %h -> %h, wb_rd %h -> %h, wb_data %h -> %h",
               $sampled(wb_valid_q), $sampled(wb_valid), $sampled(wb_rd_q),
               $sampled(wb_rd), $sampled(wb_data_q), $sampled(wb_data));
      error_count++;
    end

  a_illegal_flag: assert property (@(posedge bus) disable iff (!rst_n) illegal == bad_q)
    else begin
      $display("** Error: illegal = %h, expected %h", $sampled(illegal), $sampled(bad_q));
      error_count++;
    end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    seed        = 32'h58ad_4d77;
    rst_n       = 1'b0;
    hold        = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    pc_cur      = 32'h0000_1000;
    for (int i = 0; i < 32; i++) model[i] = '0;
    for (int i = 0; i < 3; i++) hist[i] = 5'd1;

    repeat (16) @(negedge bus);
    rst_n = 1'b1;
    idle(4);
    finish_test("reset");

    // Seed every register, then random ALU ops with gaps
    for (int i = 1; i < 32; i++) begin
      issue(enc_u(20'($random(seed)), 5'(i), OPC_LUI));
      issue(enc_i(12'($random(seed)), 5'(i), F3_ADD_SUB, 5'(i)));
    end
    for (int i = 0; i < 80; i++) begin
      issue(random_alu(rand_reg(), rand_reg(), rand_reg()));
      if ($unsigned($random(seed)) % 5 == 0) idle(1 + $unsigned($random(seed)) % 3);
    end
    finish_test("alu");

    // Random pc per instruction so auipc sees varied bases
    for (int i = 0; i < 24; i++) begin
      pc_cur = $random(seed) & ~32'h3;
      issue(enc_u(20'($random(seed)), rand_reg(), i[0] ? OPC_AUIPC : OPC_LUI));
    end
    finish_test("lui_auipc");

    // Sources taken from the last three destinations
    for (int i = 0; i < 80; i++) begin
      rs1 = hist[$unsigned($random(seed)) % 3];
      rs2 = ($random(seed) & 1) ? hist[$unsigned($random(seed)) % 3] : rand_reg();
      rd  = rand_reg();
      issue(random_alu(rs1, rs2, rd));
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = rd;
    end
    finish_test("forward");

    // Hold bursts dropped between dependent issues
    for (int i = 0; i < 60; i++) begin
      if ($unsigned($random(seed)) % 4 == 0) begin
        hold = 1'b1;
        idle(1 + $unsigned($random(seed)) % 3);
        hold = 1'b0;
      end else begin
        rd = rand_reg();
        issue(random_alu(hist[0], hist[1], rd));
        hist[1] = hist[0];
        hist[0] = rd;
      end
    end
    finish_test("hold");

    // x0 targets retire nothing, x0 sources read zero
    issue(enc_i(12'h123, 5'd5, F3_ADD_SUB, 5'd0));
    issue(enc_r(7'd0, 5'd6, 5'd7, F3_OR, 5'd0));
    issue(enc_r(7'd0, 5'd0, 5'd0, F3_ADD_SUB, 5'd7));
    issue(enc_i(12'h5a5, 5'd0, F3_OR, 5'd8));
    // Load, branch and an all-ones opcode
    issue(32'h0000_2083);
    issue(enc_i(12'h7ff, 5'd0, F3_ADD_SUB, 5'd9));
    issue(32'h0020_8463);
    idle(2);
    issue(32'hffff_ffff);
    issue(enc_r(F7_ALT, 5'd0, 5'd9, F3_ADD_SUB, 5'd10));
    finish_test("x0_illegal");

    $display("Tests %0d, issued %0d, retired %0d, errors %0d",
             test_count, issued, retired, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
